/* Makefile */
SIM        := verilator
TOP        := tb_tomasulo
RTL_TOP    := tomasulo_core
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := *** PASSED ***

.PHONY: all lint sim clean

all: sim

# Lint the design alone, then together with the testbench
lint:
	$(SIM) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(SIM) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

# Build and run, status comes from the search for the pass line
sim:
	$(SIM) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
+incdir+test
rtl/ooo_pkg.sv
rtl/int_alu.sv
rtl/reservation_station.sv
rtl/register_status.sv
rtl/tomasulo_core.sv
test/tb_tomasulo.sv

/* rtl/int_alu.sv */
`timescale 1ns/10ps

module int_alu
    import ooo_pkg::*;
#(
    parameter int   DATA_WIDTH = 32,
    parameter tag_t ALU_TAG    = 2'd0
) (
    input  logic      clk,
    input  logic      reset,
    input  logic      issue_valid,
    input  issue_t    issue,
    output logic      issue_ready,
    // Own CDB channel
    output cdb_chan_t result
);

    localparam int SHAMT_W = $clog2(DATA_WIDTH);

    logic                  fire;
    logic                  is_mul;
    logic [DATA_WIDTH-1:0] alu_out;
    logic [DATA_WIDTH-1:0] mul_lo;

    // Multiplier state, 3 down to 1, 0 is idle
    logic [1:0]            mul_cnt;
    logic [DATA_WIDTH-1:0] mul_prod;
    reg_addr_t             mul_rd;

    assign issue_ready = (mul_cnt == 2'd0);
    assign fire        = issue_valid && issue_ready;
    assign is_mul      = (issue.op == OP_MUL);
    // Low half only
    assign mul_lo      = issue.data_a * issue.data_b;

    // Single-cycle path
    always_comb begin
        case (issue.op)
            OP_ADD:  alu_out = issue.data_a + issue.data_b;
            OP_SUB:  alu_out = issue.data_a - issue.data_b;
            OP_AND:  alu_out = issue.data_a & issue.data_b;
            OP_OR:   alu_out = issue.data_a | issue.data_b;
            OP_XOR:  alu_out = issue.data_a ^ issue.data_b;
            OP_SLL:  alu_out = issue.data_a << issue.data_b[SHAMT_W-1:0];
            OP_SRL:  alu_out = issue.data_a >> issue.data_b[SHAMT_W-1:0];
            OP_SLT:  alu_out = {{(DATA_WIDTH-1){1'b0}},
                                ($signed(issue.data_a) < $signed(issue.data_b))};
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mul_cnt <= 2'd0;
        end else if (fire && is_mul) begin
            mul_cnt <= 2'd3;
        end else if (mul_cnt != 2'd0) begin
            mul_cnt <= mul_cnt - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (fire && is_mul) begin
            mul_prod <= mul_lo;
            mul_rd   <= issue.rd;
        end
    end

    // Broadcast, multiply in its last counter cycle, others on issue
    always_comb begin
        result.tag = ALU_TAG;
        if (mul_cnt == 2'd1) begin
            result.valid = 1'b1;
            result.dest  = mul_rd;
            result.data  = mul_prod;
        end else begin
            result.valid = fire && !is_mul;
            result.dest  = issue.rd;
            result.data  = alu_out;
        end
    end

    a_valid_when_idle_or_last: assert property (
        @(posedge clk) disable iff (!reset)
        result.valid |-> (mul_cnt == 2'd0) || (mul_cnt == 2'd1)
    ) else $error("int_alu %0d: broadcast mid-multiply", ALU_TAG);

endmodule

/* rtl/ooo_pkg.sv */
package ooo_pkg;

    // ========================================================================
    // Sizes and tags
    // ========================================================================

    localparam int XLEN      = 32;
    localparam int NUM_ALUS  = 3;
    localparam int IMM_WIDTH = 6;

    // Producer tag, 0..2 name an ALU
    typedef logic [1:0] tag_t;
    localparam tag_t TAG_READY = 2'd3;

    typedef logic [2:0] reg_addr_t;

    // ========================================================================
    // Instruction word
    // ========================================================================

    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SLT = 4'd7,
        OP_MUL = 4'd8
    } alu_op_t;

    // Immediate-form flag sits above the operation code
    typedef struct packed {
        logic    imm;
        alu_op_t op;
    } opcode_t;

    // Register form, 17 bits
    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic [2:0] pad;
    } instr_r_t;

    // Immediate form, same width, rs2 and pad become the immediate
    typedef struct packed {
        opcode_t                       opcode;
        reg_addr_t                     rd;
        reg_addr_t                     rs1;
        logic signed [IMM_WIDTH-1:0]   imm;
    } instr_i_t;

    // Decoded as either form by opcode.imm
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // ========================================================================
    // Pipeline payloads and CDB
    // ========================================================================

    // Operand value, or the ALU it waits for
    typedef struct packed {
        tag_t             tag;
        logic [XLEN-1:0]  data;
    } operand_t;

    typedef struct packed {
        alu_op_t   op;
        reg_addr_t rd;
        operand_t  a;
        operand_t  b;
    } dispatch_t;

    typedef struct packed {
        alu_op_t          op;
        reg_addr_t        rd;
        logic [XLEN-1:0]  data_a;
        logic [XLEN-1:0]  data_b;
    } issue_t;

    typedef struct packed {
        logic             valid;
        tag_t             tag;
        reg_addr_t        dest;
        logic [XLEN-1:0]  data;
    } cdb_chan_t;

    // One channel per ALU, index equals tag
    typedef cdb_chan_t [NUM_ALUS-1:0] cdb_bus_t;

    // Snoop the bus: a waiting operand takes the data of its producer
    function automatic operand_t cdb_capture(input operand_t opnd, input cdb_bus_t cdb);
        operand_t res;
        res = opnd;
        for (int k = 0; k < NUM_ALUS; k++) begin
            if (res.tag != TAG_READY && cdb[k].valid && cdb[k].tag == res.tag) begin
                res.tag  = TAG_READY;
                res.data = cdb[k].data;
            end
        end
        return res;
    endfunction

endpackage

/* rtl/register_status.sv */
`timescale 1ns/10ps

module register_status
    import ooo_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  instr_u              instr,
    input  logic [1:0]          unit,
    output logic                instr_ready,
    output logic [NUM_ALUS-1:0] dispatch_valid,
    output dispatch_t           dispatch,
    input  logic [NUM_ALUS-1:0] dispatch_ready,
    input  cdb_bus_t            cdb
);

    localparam int NUM_REGS = 8;

    // ========================================================================
    // Architectural state
    // ========================================================================

    logic [DATA_WIDTH-1:0] regs [NUM_REGS];
    tag_t                  tags [NUM_REGS];
    // One instruction in flight per ALU
    logic [NUM_ALUS-1:0]   busy;

    logic                  accept;
    operand_t              src_a;
    operand_t              src_b;
    logic [DATA_WIDTH-1:0] imm_ext;

    // Register read with same-cycle CDB bypass
    function automatic operand_t read_src(input reg_addr_t addr);
        operand_t opnd;
        opnd.tag  = tags[addr];
        opnd.data = regs[addr];
        return cdb_capture(opnd, cdb);
    endfunction

    // ========================================================================
    // Decode and dispatch
    // ========================================================================

    // Unit must be free and its station ready, unit 3 never accepts
    always_comb begin
        instr_ready = 1'b0;
        for (int k = 0; k < NUM_ALUS; k++) begin
            if (unit == 2'(k)) begin
                instr_ready = dispatch_ready[k] && !busy[k];
            end
        end
    end

    assign accept = instr_valid && instr_ready;

    always_comb begin
        for (int k = 0; k < NUM_ALUS; k++) begin
            dispatch_valid[k] = accept && (unit == 2'(k));
        end
    end

    // rs1 sits in the same place in both forms
    assign src_a   = read_src(instr.r.rs1);
    assign src_b   = read_src(instr.r.rs2);
    assign imm_ext = {{(DATA_WIDTH-IMM_WIDTH){instr.i.imm[IMM_WIDTH-1]}}, instr.i.imm};

    always_comb begin
        dispatch.op = instr.r.opcode.op;
        dispatch.rd = instr.r.rd;
        dispatch.a  = src_a;
        // Immediate replaces rs2 and is always ready
        if (instr.i.opcode.imm) begin
            dispatch.b.tag  = TAG_READY;
            dispatch.b.data = imm_ext;
        end else begin
            dispatch.b = src_b;
        end
    end

    // ========================================================================
    // Writeback and retag
    // ========================================================================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < NUM_REGS; r++) begin
                regs[r] <= '0;
                tags[r] <= TAG_READY;
            end
            busy <= '0;
        end else begin
            for (int k = 0; k < NUM_ALUS; k++) begin
                if (cdb[k].valid) begin
                    busy[k] <= 1'b0;
                    // Only the newest producer of rd may write it
                    if (tags[cdb[k].dest] == tag_t'(k)) begin
                        regs[cdb[k].dest] <= cdb[k].data;
                        tags[cdb[k].dest] <= TAG_READY;
                    end
                end
            end
            // Retag wins over a same-cycle broadcast
            if (accept) begin
                tags[instr.r.rd] <= unit;
                busy[unit]       <= 1'b1;
            end
        end
    end

    a_unit_in_range: assert property (
        @(posedge clk) disable iff (!reset)
        instr_valid |-> (unit != 2'd3)
    ) else $error("register_status: instruction for unit 3");

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/10ps

module reservation_station
    import ooo_pkg::*;
#(
    // Tag of the ALU behind this station
    parameter tag_t ALU_TAG = 2'd0
) (
    input  logic      clk,
    input  logic      reset,

    // From register status
    input  logic      dispatch_valid,
    input  dispatch_t dispatch,
    output logic      dispatch_ready,

    // Whole CDB, snooped for waiting operands
    input  cdb_bus_t  cdb,

    // To the ALU
    output logic      issue_valid,
    output issue_t    issue,
    input  logic      issue_ready
);

    // ========================================================================
    // Entry storage
    // ========================================================================

    logic      occupied;
    alu_op_t   ent_op;
    reg_addr_t ent_rd;
    operand_t  ent_a;
    operand_t  ent_b;

    // Both operands present
    logic      entry_ready;
    // Issue register empty or draining this cycle
    logic      issue_free;
    // Entry moves into the issue register at the next edge
    logic      move;

    assign entry_ready = occupied && (ent_a.tag == TAG_READY) && (ent_b.tag == TAG_READY);
    assign issue_free  = !issue_valid || issue_ready;
    assign move        = entry_ready && issue_free;

    // Free slot, or slot freed by the move
    assign dispatch_ready = !occupied || move;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            occupied <= 1'b0;
        end else if (dispatch_valid) begin
            occupied <= 1'b1;
        end else if (move) begin
            occupied <= 1'b0;
        end
    end

    // Payload and operand capture
    always_ff @(posedge clk) begin
        if (dispatch_valid) begin
            ent_op <= dispatch.op;
            ent_rd <= dispatch.rd;
            // Dispatch already carries same-cycle bypass
            ent_a  <= dispatch.a;
            ent_b  <= dispatch.b;
        end else begin
            // Waiting operands pick up their broadcast
            ent_a  <= cdb_capture(ent_a, cdb);
            ent_b  <= cdb_capture(ent_b, cdb);
        end
    end

    // ========================================================================
    // Issue register
    // ========================================================================

    // Held while the ALU stalls
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid <= 1'b0;
        end else if (issue_free) begin
            issue_valid <= entry_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (move) begin
            issue.op     <= ent_op;
            issue.rd     <= ent_rd;
            issue.data_a <= ent_a.data;
            issue.data_b <= ent_b.data;
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    // Register status honours the ready of this station
    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!reset)
        dispatch_valid |-> dispatch_ready
    ) else $error("reservation_station %0d: dispatch while full", ALU_TAG);

    // Own ALU is idle whenever new work arrives, so nothing waits on it
    a_no_self_wait: assert property (
        @(posedge clk) disable iff (!reset)
        dispatch_valid |-> (dispatch.a.tag != ALU_TAG) && (dispatch.b.tag != ALU_TAG)
    ) else $error("reservation_station %0d: operand waits on own ALU", ALU_TAG);

endmodule

/* rtl/tomasulo_core.sv */
`timescale 1ns/10ps

module tomasulo_core
    import ooo_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic       clk,
    input  logic       reset,

    // In-order instruction port
    input  logic       instr_valid,
    input  instr_u     instr,
    input  logic [1:0] unit,
    output logic       instr_ready,

    // Result broadcast, one channel per ALU
    output cdb_bus_t   cdb
);

    logic [NUM_ALUS-1:0] dispatch_valid;
    logic [NUM_ALUS-1:0] dispatch_ready;
    dispatch_t           dispatch;

    logic [NUM_ALUS-1:0] issue_valid;
    logic [NUM_ALUS-1:0] issue_ready;
    issue_t              issue [NUM_ALUS];

    // Struct payloads are sized by the package
    initial begin
        assert (XLEN == DATA_WIDTH)
            else $fatal(1, "tomasulo_core: DATA_WIDTH %0d differs from XLEN", DATA_WIDTH);
    end

    // ========================================================================
    // Front end
    // ========================================================================

    register_status #(
        .DATA_WIDTH (DATA_WIDTH)
    ) i_register_status (
        .clk            (clk),
        .reset          (reset),
        .instr_valid    (instr_valid),
        .instr          (instr),
        .unit           (unit),
        .instr_ready    (instr_ready),
        .dispatch_valid (dispatch_valid),
        .dispatch       (dispatch),
        .dispatch_ready (dispatch_ready),
        .cdb            (cdb)
    );

    // ========================================================================
    // Station and ALU per lane, lane k owns CDB channel k
    // ========================================================================

    for (genvar k = 0; k < NUM_ALUS; k++) begin : gen_lane
        reservation_station #(
            .ALU_TAG (tag_t'(k))
        ) i_reservation_station (
            .clk            (clk),
            .reset          (reset),
            .dispatch_valid (dispatch_valid[k]),
            .dispatch       (dispatch),
            .dispatch_ready (dispatch_ready[k]),
            .cdb            (cdb),
            .issue_valid    (issue_valid[k]),
            .issue          (issue[k]),
            .issue_ready    (issue_ready[k])
        );

        int_alu #(
            .DATA_WIDTH (DATA_WIDTH),
            .ALU_TAG    (tag_t'(k))
        ) i_int_alu (
            .clk         (clk),
            .reset       (reset),
            .issue_valid (issue_valid[k]),
            .issue       (issue[k]),
            .issue_ready (issue_ready[k]),
            .result      (cdb[k])
        );
    end

endmodule

/* test/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ============================================================================
// Stimulus record and expected results
// ============================================================================

// One generated instruction, kept until the core accepts it
typedef struct packed {
    logic [1:0] unit;
    alu_op_t    op;
    logic       imm;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [5:0] imm_val;
    // Reads a destination of the last four instructions
    logic       dep;
} stim_t;

// Broadcast predicted for one accepted instruction
typedef struct packed {
    reg_addr_t       dest;
    logic [XLEN-1:0] data;
    logic            dep;
    logic            imm;
} expect_t;

// In-order copy of the architectural registers
logic [XLEN-1:0] model_regs [8];

// Expected results per ALU, in program order
expect_t alu0_q [$];
expect_t alu1_q [$];
expect_t alu2_q [$];

// ============================================================================
// Opcode evaluator
// ============================================================================

function automatic logic [XLEN-1:0] sext_imm(input logic [5:0] v);
    return {{(XLEN-6){v[5]}}, v};
endfunction

function automatic logic [XLEN-1:0] eval_op(input alu_op_t op, input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
    logic [2*XLEN-1:0] prod;
    prod = 64'(a) * 64'(b);
    case (op)
        OP_ADD:  return a + b;
        OP_SUB:  return a - b;
        OP_AND:  return a & b;
        OP_OR:   return a | b;
        OP_XOR:  return a ^ b;
        // Shift amount is the low five bits of B
        OP_SLL:  return a << b[4:0];
        OP_SRL:  return a >> b[4:0];
        OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // Low half of the product
        OP_MUL:  return prod[XLEN-1:0];
        default: return '0;
    endcase
endfunction

// ============================================================================
// Queue access
// ============================================================================

task automatic reset_model();
    for (int r = 0; r < 8; r++) begin
        model_regs[r] = '0;
    end
    alu0_q.delete();
    alu1_q.delete();
    alu2_q.delete();
endtask

task automatic push_expected(input logic [1:0] u, input expect_t e);
    case (u)
        2'd0:    alu0_q.push_back(e);
        2'd1:    alu1_q.push_back(e);
        default: alu2_q.push_back(e);
    endcase
endtask

function automatic int pending_count(input int u);
    case (u)
        0:       return alu0_q.size();
        1:       return alu1_q.size();
        default: return alu2_q.size();
    endcase
endfunction

task automatic pop_expected(input int u, output expect_t e);
    case (u)
        0:       e = alu0_q.pop_front();
        1:       e = alu1_q.pop_front();
        default: e = alu2_q.pop_front();
    endcase
endtask

// Program-order execution of one accepted instruction
task automatic apply_instr(input stim_t s);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    expect_t         e;
    a = model_regs[s.rs1];
    // Immediate form takes the sign-extended immediate in place of rs2
    b = s.imm ? sext_imm(s.imm_val) : model_regs[s.rs2];
    res = eval_op(s.op, a, b);
    model_regs[s.rd] = res;
    e.dest = s.rd;
    e.data = res;
    e.dep  = s.dep;
    e.imm  = s.imm;
    push_expected(s.unit, e);
endtask

`endif

/* test/tb_tomasulo.sv */
`timescale 1ns/10ps

module tb_tomasulo
    import ooo_pkg::*;
();

    localparam int NUM_INSTR    = 400;
    localparam int CLK_PERIOD   = 8;
    // Generous per-instruction budget, a serial multiply chain needs about six
    localparam int CYCLE_BUDGET = 10;
    localparam int TIMEOUT_NS   = NUM_INSTR * CYCLE_BUDGET * CLK_PERIOD + 200 * CLK_PERIOD;
    // Three chained multiplies in flight finish well inside this
    localparam int DRAIN_LIMIT  = 40;
    localparam int SEED         = 57475;

    logic       clk;
    logic       reset;
    logic       instr_valid;
    instr_u     instr;
    logic [1:0] unit;
    logic       instr_ready;
    cdb_bus_t   cdb;

    `include "tb_model.svh"

    // Driver state
    stim_t     cur;
    int        n_issued;
    int        reset_errors;
    int        end_errors;
    reg_addr_t recent_rd [4];

    // Monitor state
    int n_accepted  = 0;
    int cdb_count   = 0;
    int cdb_checks  = 0;
    int cdb_errors  = 0;
    int dep_checks  = 0;
    int dep_errors  = 0;
    int imm_checks  = 0;
    int reg_checks  = 0;
    int form_errors = 0;
    bit seen_form [9][2];

    tomasulo_core #(
        .DATA_WIDTH (32)
    ) i_tomasulo_core (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .unit        (unit),
        .instr_ready (instr_ready),
        .cdb         (cdb)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic present_next();
        stim_t s;
        int    d;
        s.unit    = 2'($urandom_range(2, 0));
        s.op      = alu_op_t'(4'($urandom_range(8, 0)));
        s.imm     = 1'($urandom_range(1, 0));
        s.rd      = reg_addr_t'($urandom_range(7, 0));
        s.rs2     = reg_addr_t'($urandom_range(7, 0));
        s.imm_val = 6'($urandom_range(63, 0));
        s.dep     = 1'b0;
        // Mostly read a recent destination, RAW distance 0 to 3
        d = $urandom_range(3, 0);
        if ($urandom_range(3, 0) != 0) begin
            s.rs1 = recent_rd[2'(d)];
            s.dep = 1'b1;
        end else begin
            s.rs1 = reg_addr_t'($urandom_range(7, 0));
        end
        d = $urandom_range(3, 0);
        if (!s.imm && $urandom_range(1, 0) != 0) begin
            s.rs2 = recent_rd[2'(d)];
            s.dep = 1'b1;
        end
        recent_rd[3] = recent_rd[2];
        recent_rd[2] = recent_rd[1];
        recent_rd[1] = recent_rd[0];
        recent_rd[0] = s.rd;
        // Encode the word in the form its flag selects
        instr = '0;
        if (s.imm) begin
            instr.i.opcode.imm = 1'b1;
            instr.i.opcode.op  = s.op;
            instr.i.rd         = s.rd;
            instr.i.rs1        = s.rs1;
            instr.i.imm        = s.imm_val;
        end else begin
            instr.r.opcode.imm = 1'b0;
            instr.r.opcode.op  = s.op;
            instr.r.rd         = s.rd;
            instr.r.rs1        = s.rs1;
            instr.r.rs2        = s.rs2;
        end
        cur         = s;
        unit        = s.unit;
        instr_valid = 1'b1;
        n_issued++;
    endtask

    // ========================================================================
    // Monitor, sampled at the falling edge where everything has settled
    // ========================================================================

    task automatic check_broadcast(input int k);
        expect_t   want;
        cdb_chan_t got;
        bit        bad;
        got = cdb[k];
        bad = 1'b0;
        cdb_count++;
        assert (pending_count(k) > 0) else begin
            $display("ERROR: result on cdb[%0d] with no instruction outstanding on that unit", k);
            cdb_errors++;
        end
        if (pending_count(k) > 0) begin
            pop_expected(k, want);
            cdb_checks++;
            assert (got.tag == tag_t'(k)) else begin
                $display("MISMATCH cdb[%0d].tag got %h expected %h", k, got.tag, tag_t'(k));
                bad = 1'b1;
                cdb_errors++;
            end
            assert (got.dest == want.dest) else begin
                $display("MISMATCH cdb[%0d].dest got %h expected %h", k, got.dest, want.dest);
                bad = 1'b1;
                cdb_errors++;
            end
            assert (got.data == want.data) else begin
                $display("MISMATCH cdb[%0d].data got %h expected %h", k, got.data, want.data);
                bad = 1'b1;
                cdb_errors++;
            end
            // Sort the outcome into chain and operand-form buckets
            if (want.dep) begin
                dep_checks++;
                dep_errors += int'(bad);
            end
            if (want.imm) begin
                imm_checks++;
            end else begin
                reg_checks++;
            end
            form_errors += int'(bad);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            reset_model();
        end else begin
            // Results first, they belong to earlier accepts
            for (int k = 0; k < NUM_ALUS; k++) begin
                if (cdb[k].valid) begin
                    check_broadcast(k);
                end
            end
            // Transfer at the coming rising edge
            if (instr_valid && instr_ready) begin
                apply_instr(cur);
                seen_form[cur.op][cur.imm] = 1'b1;
                n_accepted++;
            end
        end
    end

    // ========================================================================
    // Watchdog
    // ========================================================================

    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: watchdog expired at %0t, %0d of %0d instructions accepted",
                 $time, n_accepted, NUM_INSTR);
        $display("*** FAILED ***");
        $finish;
    end

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        int n_seen;
        int total_errors;
        int drain_cycles;
        void'($urandom(SEED));
        reset        = 1'b0;
        instr_valid  = 1'b0;
        instr        = '0;
        unit         = 2'd0;
        cur          = '0;
        n_issued     = 0;
        reset_errors = 0;
        end_errors   = 0;
        for (int i = 0; i < 4; i++) begin
            recent_rd[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1 reset = 1'b1;

        // Behavior 1, idle state after reset
        @(negedge clk);
        assert (instr_ready === 1'b1) else begin
            $display("ERROR: instr_ready is not high after reset");
            reset_errors++;
        end
        for (int k = 0; k < NUM_ALUS; k++) begin
            assert (cdb[k].valid === 1'b0) else begin
                $display("MISMATCH cdb[%0d].valid got %h expected 0", k, cdb[k].valid);
                reset_errors++;
            end
        end
        $display("test 1 reset state: %s", (reset_errors == 0) ? "ok" : "fail");

        // Hold each instruction until the monitor has seen it accepted
        @(posedge clk);
        #1;
        present_next();
        while (n_accepted < NUM_INSTR) begin
            @(posedge clk);
            #1;
            if (n_accepted == n_issued) begin
                if (n_issued < NUM_INSTR) begin
                    present_next();
                end else begin
                    instr_valid = 1'b0;
                end
            end
        end

        // Drain the in-flight results for a bounded time, then watch for strays
        drain_cycles = 0;
        while (pending_count(0) + pending_count(1) + pending_count(2) != 0 &&
               drain_cycles < DRAIN_LIMIT) begin
            @(negedge clk);
            drain_cycles++;
        end
        repeat (4) @(negedge clk);

        $display("test 2 cdb tag, dest and data: %0d broadcasts, %0d errors",
                 cdb_count, cdb_errors);
        $display("test 3 dependent chains: %0d results checked, %0d wrong",
                 dep_checks, dep_errors);

        // Behavior 4, all nine opcodes in both forms
        n_seen = 0;
        for (int op = 0; op < 9; op++) begin
            for (int f = 0; f < 2; f++) begin
                n_seen += int'(seen_form[op][f]);
            end
        end
        assert (n_seen == 18) else begin
            $display("ERROR: only %0d of 18 opcode and form pairs were exercised", n_seen);
            end_errors++;
        end
        $display("test 4 operand forms: %0d immediate, %0d register, %0d pairs, %0d wrong",
                 imm_checks, reg_checks, n_seen, form_errors);

        // Behavior 5, nothing left over and nothing lost
        assert (pending_count(0) + pending_count(1) + pending_count(2) == 0) else begin
            $display("ERROR: %0d expected results were never broadcast",
                     pending_count(0) + pending_count(1) + pending_count(2));
            end_errors++;
        end
        assert (n_accepted == cdb_count) else begin
            $display("ERROR: %0d instructions accepted but %0d results broadcast",
                     n_accepted, cdb_count);
            end_errors++;
        end
        $display("test 5 accounting: %0d accepted, %0d broadcast: %s",
                 n_accepted, cdb_count,
                 (n_accepted == cdb_count) ? "ok" : "fail");

        total_errors = reset_errors + cdb_errors + end_errors;
        $display("checks %0d, errors %0d, accepted %0d, broadcasts %0d",
                 cdb_checks + 2 + NUM_ALUS, total_errors, n_accepted, cdb_count);
        if (total_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
